// File: verilog.f
+incdir+dv
design/rv_isa_pkg.sv
design/id_pipe_pkg.sv
design/id_decoder.sv
design/id_operand_sel.sv
design/id_ex_pipe_reg.sv
design/id_stage.sv
dv/tb_id_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f verilog.f \
  --top-module tb_id_stage \
  -Mdir obj_dir \
  -o sim_id_stage

./obj_dir/sim_id_stage

// File: dv/id_ref_model.svh
// Decode stage reference model, included in the testbench module body to predict ID/EX contents

// Prediction for one ID cycle
typedef struct packed {
  // Fields as they would load on a transfer
  id_ex_pipe_t cand;
  logic        use_a;
  logic        use_b;
  logic        use_c;
  logic [1:0]  rf_re;
  // Target only defined for jumps and branches
  logic        tgt_known;
  word_t       tgt;
} model_out_t;

// Forwarding choice for one source operand
function automatic word_t forward_value(fw_sel_e sel, word_t ex, word_t wb, word_t rf);
  word_t v;
  v = rf;
  if (sel == SEL_FW_EX) begin
    v = ex;
  end else if (sel == SEL_FW_WB) begin
    v = wb;
  end
  return v;
endfunction

function automatic model_out_t predict_decode(logic [31:0] w, word_t pc, ctrl_t c,
                                              word_t rda, word_t rdb, word_t ex, word_t wb);
  model_out_t m;
  logic [2:0] f3;
  logic       legal;
  word_t      src_a;
  word_t      src_b;
  word_t      jalr_base;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;
  f3    = w[14:12];
  // Immediates straight from the instruction bits
  imm_i = {{20{w[31]}}, w[31:20]};
  imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
  imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
  imm_u = {w[31:12], 12'b0};
  imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
  src_a = forward_value(c.op_a_fw_sel, ex, wb, rda);
  src_b = forward_value(c.op_b_fw_sel, ex, wb, rdb);
  // Jump base takes WB or the register file only
  jalr_base = (c.jalr_fw_sel == SEL_FW_WB) ? wb : rda;
  legal = 1'b1;
  m = '0;
  m.cand.instr_valid  = 1'b1;
  m.cand.pc           = pc;
  m.cand.alu_operator = ALU_ADD;
  m.cand.rf_waddr     = w[11:7];
  case (w[6:0])
    OPC_OP, OPC_OPIMM: begin
      m.cand.alu_en    = 1'b1;
      m.cand.rf_we     = 1'b1;
      m.use_a          = 1'b1;
      m.use_b          = 1'b1;
      m.cand.operand_a = src_a;
      if (w[6:0] == OPC_OP) begin
        m.cand.operand_b = src_b;
        m.rf_re          = 2'b11;
      end else begin
        m.cand.operand_b = imm_i;
        m.rf_re          = 2'b01;
      end
      case (f3)
        3'd0: m.cand.alu_operator = (w[6:0] == OPC_OP && w[30]) ? ALU_SUB : ALU_ADD;
        3'd1: m.cand.alu_operator = ALU_SLL;
        3'd2: m.cand.alu_operator = ALU_SLT;
        3'd3: m.cand.alu_operator = ALU_SLTU;
        3'd4: m.cand.alu_operator = ALU_XOR;
        3'd5: m.cand.alu_operator = w[30] ? ALU_SRA : ALU_SRL;
        3'd6: m.cand.alu_operator = ALU_OR;
        default: m.cand.alu_operator = ALU_AND;
      endcase
    end
    OPC_LUI, OPC_AUIPC: begin
      m.cand.alu_en    = 1'b1;
      m.cand.rf_we     = 1'b1;
      m.use_a          = 1'b1;
      m.use_b          = 1'b1;
      m.cand.operand_a = (w[6:0] == OPC_LUI) ? 32'd0 : pc;
      m.cand.operand_b = imm_u;
    end
    OPC_JAL, OPC_JALR: begin
      // Link address PC + 4
      m.cand.alu_en    = 1'b1;
      m.cand.alu_jmp   = 1'b1;
      m.cand.rf_we     = 1'b1;
      m.use_a          = 1'b1;
      m.use_b          = 1'b1;
      m.cand.operand_a = pc;
      m.cand.operand_b = 32'd4;
      m.tgt_known      = 1'b1;
      if (w[6:0] == OPC_JALR) begin
        m.rf_re = 2'b01;
        m.tgt   = (jalr_base + imm_i) & ~32'd1;
      end else begin
        m.tgt = pc + imm_j;
      end
    end
    OPC_BRANCH: begin
      m.cand.alu_en    = 1'b1;
      m.cand.alu_bch   = 1'b1;
      m.use_a          = 1'b1;
      m.use_b          = 1'b1;
      m.use_c          = 1'b1;
      m.cand.operand_a = src_a;
      m.cand.operand_b = src_b;
      m.cand.operand_c = pc + imm_b;
      m.rf_re          = 2'b11;
      m.tgt_known      = 1'b1;
      m.tgt            = pc + imm_b;
      case (f3)
        3'd0: m.cand.alu_operator = ALU_EQ;
        3'd1: m.cand.alu_operator = ALU_NE;
        3'd4: m.cand.alu_operator = ALU_LT;
        3'd5: m.cand.alu_operator = ALU_GE;
        3'd6: m.cand.alu_operator = ALU_LTU;
        3'd7: m.cand.alu_operator = ALU_GEU;
        default: legal = 1'b0;
      endcase
    end
    OPC_LOAD, OPC_STORE: begin
      m.cand.lsu_en    = 1'b1;
      m.cand.lsu_size  = lsu_size_e'(f3[1:0]);
      m.use_a          = 1'b1;
      m.use_b          = 1'b1;
      m.cand.operand_a = src_a;
      if (w[6:0] == OPC_LOAD) begin
        // LB LH LW LBU LHU
        legal            = f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
        m.cand.rf_we     = 1'b1;
        m.cand.lsu_sext  = !f3[2];
        m.cand.operand_b = imm_i;
        m.rf_re          = 2'b01;
      end else begin
        legal            = f3 inside {3'd0, 3'd1, 3'd2};
        m.cand.lsu_we    = 1'b1;
        m.cand.operand_b = imm_s;
        // Store data from rs2
        m.use_c          = 1'b1;
        m.cand.operand_c = src_b;
        m.rf_re          = 2'b11;
      end
    end
    default: legal = 1'b0;
  endcase
  // Illegal word: no unit, no operand, both read ports on
  if (!legal) begin
    m = '0;
    m.cand.instr_valid  = 1'b1;
    m.cand.pc           = pc;
    m.cand.illegal_insn = 1'b1;
    m.rf_re             = 2'b11;
  end
  return m;
endfunction

// Next register contents, fields held unless their unit uses them
function automatic id_ex_pipe_t next_pipe(id_ex_pipe_t cur, model_out_t m, logic valid,
                                          logic ex_ready);
  id_ex_pipe_t n;
  n = cur;
  if (valid && ex_ready) begin
    n.instr_valid  = 1'b1;
    n.pc           = m.cand.pc;
    n.alu_operator = m.cand.alu_operator;
    n.illegal_insn = m.cand.illegal_insn;
    n.alu_en       = m.cand.alu_en;
    n.lsu_en       = m.cand.lsu_en;
    n.rf_we        = m.cand.rf_we;
    if (m.use_a) n.operand_a = m.cand.operand_a;
    if (m.use_b) n.operand_b = m.cand.operand_b;
    if (m.use_c) n.operand_c = m.cand.operand_c;
    if (m.cand.alu_en) begin
      n.alu_bch = m.cand.alu_bch;
      n.alu_jmp = m.cand.alu_jmp;
    end
    if (m.cand.lsu_en) begin
      n.lsu_we   = m.cand.lsu_we;
      n.lsu_size = m.cand.lsu_size;
      n.lsu_sext = m.cand.lsu_sext;
    end
    if (m.cand.rf_we) n.rf_waddr = m.cand.rf_waddr;
  end else if (ex_ready) begin
    // Bubble
    n.instr_valid = 1'b0;
  end
  return n;
endfunction

// File: dv/tb_id_stage.sv
// Testbench for the decode stage, random instructions checked against an included model
module tb_id_stage;

  import rv_isa_pkg::*;
  import id_pipe_pkg::*;

  `include "id_ref_model.svh"

  localparam int N_INSTR  = 3000;
  localparam int MAX_WAIT = 64;

  logic        clk;
  logic        rst_n;
  if_id_pipe_t if_id_pipe;
  ctrl_t       ctrl;
  word_t       rf_rdata_a;
  word_t       rf_rdata_b;
  word_t       fw_ex_data;
  word_t       fw_wb_data;
  logic        ex_ready;
  rf_addr_t    rf_raddr_a;
  rf_addr_t    rf_raddr_b;
  logic [1:0]  rf_re;
  word_t       jmp_target;
  logic        id_ready;
  logic        id_valid;
  id_ex_pipe_t id_ex_pipe;

  integer      seed;
  id_ex_pipe_t exp_pipe;
  id_ex_pipe_t exp_next;
  logic        stage_ready;
  int          n_xfer;
  int          n_illegal;
  int          n_stall;

  id_stage u_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .if_id_pipe_i (if_id_pipe),
    .ctrl_i       (ctrl),
    .rf_rdata_a_i (rf_rdata_a),
    .rf_rdata_b_i (rf_rdata_b),
    .fw_ex_data_i (fw_ex_data),
    .fw_wb_data_i (fw_wb_data),
    .ex_ready_i   (ex_ready),
    .rf_raddr_a_o (rf_raddr_a),
    .rf_raddr_b_o (rf_raddr_b),
    .rf_re_o      (rf_re),
    .jmp_target_o (jmp_target),
    .id_ready_o   (id_ready),
    .id_valid_o   (id_valid),
    .id_ex_pipe_o (id_ex_pipe)
  );

  always #50 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////
  task automatic check_pipe(string name, id_ex_pipe_t act, id_ex_pipe_t exp);
    if (act !== exp) begin
      $display("error %s got %h expected %h", name, act, exp);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  task automatic check_word(string name, word_t act, word_t exp);
    if (act !== exp) begin
      $display("error %s got %h expected %h", name, act, exp);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  task automatic check_addr(string name, rf_addr_t act, rf_addr_t exp);
    if (act !== exp) begin
      $display("error %s got %h expected %h", name, act, exp);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  // Ready, valid and read enables
  task automatic check_bits(string name, logic [1:0] act, logic [1:0] exp);
    if (act !== exp) begin
      $display("error %s got %h expected %h", name, act, exp);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] next_rand();
    logic [31:0] r;
    r = $random(seed);
    return r;
  endfunction

  function automatic fw_sel_e random_fw_sel();
    logic [31:0] r;
    r = next_rand();
    case (r % 3)
      0:       return SEL_FW_EX;
      1:       return SEL_FW_WB;
      default: return SEL_REGFILE;
    endcase
  endfunction

  // Mostly kept opcodes, some raw words for illegal encodings
  function automatic logic [31:0] random_instr();
    logic [31:0] w;
    logic [31:0] pick;
    w    = next_rand();
    pick = next_rand();
    case (pick[3:0])
      4'd0, 4'd1:   w = {1'b0, w[30], 5'b0, w[24:7], OPC_OP};
      4'd2, 4'd3:   w[6:0] = OPC_OPIMM;
      4'd4:         w[6:0] = OPC_LUI;
      4'd5:         w[6:0] = OPC_AUIPC;
      4'd6:         w[6:0] = OPC_JAL;
      4'd7:         w[6:0] = OPC_JALR;
      4'd8, 4'd9:   w[6:0] = OPC_BRANCH;
      4'd10, 4'd11: w[6:0] = OPC_LOAD;
      4'd12, 4'd13: w[6:0] = OPC_STORE;
      default:      w = next_rand();
    endcase
    return w;
  endfunction

  // Per-cycle levels and data, instruction stays put
  task automatic drive_cycle();
    logic [31:0] r;
    r = next_rand();
    ctrl.kill_id     = r[3:0] == 4'd0;
    ctrl.halt_id     = r[7:4] == 4'd0;
    ex_ready         = r[9:8] != 2'd0;
    ctrl.op_a_fw_sel = random_fw_sel();
    ctrl.op_b_fw_sel = random_fw_sel();
    ctrl.jalr_fw_sel = random_fw_sel();
    rf_rdata_a       = next_rand();
    rf_rdata_b       = next_rand();
    fw_ex_data       = next_rand();
    fw_wb_data       = next_rand();
  endtask

  // Combinational checks mid-cycle, then predict the next register
  task automatic check_cycle();
    logic [31:0] w;
    model_out_t  m;
    logic        exp_valid;
    logic        exp_ready;
    w = if_id_pipe.instr;
    m = predict_decode(w, if_id_pipe.pc, ctrl, rf_rdata_a, rf_rdata_b, fw_ex_data, fw_wb_data);
    exp_valid = if_id_pipe.instr_valid && !ctrl.kill_id && !ctrl.halt_id;
    exp_ready = ctrl.kill_id || (ex_ready && !ctrl.halt_id);
    check_bits("id_valid_o", {1'b0, id_valid}, {1'b0, exp_valid});
    check_bits("id_ready_o", {1'b0, id_ready}, {1'b0, exp_ready});
    check_bits("rf_re_o", rf_re, m.rf_re);
    check_addr("rf_raddr_a_o", rf_raddr_a, w[19:15]);
    check_addr("rf_raddr_b_o", rf_raddr_b, w[24:20]);
    if (m.tgt_known) begin
      check_word("jmp_target_o", jmp_target, m.tgt);
    end
    exp_next    = next_pipe(exp_pipe, m, exp_valid, ex_ready);
    stage_ready = exp_ready;
    if (exp_valid && ex_ready) begin
      n_xfer++;
      if (m.cand.illegal_insn) n_illegal++;
    end
    if (exp_valid && !ex_ready) n_stall++;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    logic [31:0] r;
    int          wait_cnt;
    logic        accepted;
    seed        = 32'h72e7622e;
    clk         = 1'b0;
    rst_n       = 1'b0;
    if_id_pipe  = '0;
    ctrl        = '0;
    rf_rdata_a  = '0;
    rf_rdata_b  = '0;
    fw_ex_data  = '0;
    fw_wb_data  = '0;
    ex_ready    = 1'b0;
    exp_pipe    = '0;
    exp_next    = '0;
    stage_ready = 1'b0;
    n_xfer      = 0;
    n_illegal   = 0;
    n_stall     = 0;
    repeat (10) @(posedge clk);
    #5;
    rst_n = 1'b1;
    // Register empty out of reset
    check_pipe("id_ex_pipe_o", id_ex_pipe, '0);
    for (int i = 0; i < N_INSTR; i++) begin
      r                      = next_rand();
      if_id_pipe.instr_valid = r[2:0] != 3'd0;
      r                      = next_rand();
      if_id_pipe.pc          = {r[31:2], 2'b00};
      if_id_pipe.instr       = random_instr();
      accepted               = 1'b0;
      wait_cnt               = 0;
      // Fetch holds the word until the stage is ready
      while (!accepted) begin
        if (wait_cnt == MAX_WAIT) begin
          $display("timeout, decode stage did not accept the instruction in %0d cycles",
                   MAX_WAIT);
          $display("sim failed");
          $fatal(1);
        end
        drive_cycle();
        @(negedge clk);
        check_cycle();
        accepted = stage_ready;
        @(posedge clk);
        #5;
        exp_pipe = exp_next;
        check_pipe("id_ex_pipe_o", id_ex_pipe, exp_pipe);
        wait_cnt++;
      end
    end
    if (n_xfer == 0 || n_illegal == 0 || n_stall == 0) begin
      $display("stimulus never reached a transfer, an illegal transfer or a stall");
      $display("sim failed");
      $fatal(1);
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule

// File: design/id_stage.sv
// RV32I decode stage top, chains decoder, operand selection and the ID/EX register
module id_stage (
  input  logic                     clk,
  input  logic                     rst_n,
  input  id_pipe_pkg::if_id_pipe_t if_id_pipe_i,
  input  id_pipe_pkg::ctrl_t       ctrl_i,
  input  rv_isa_pkg::word_t        rf_rdata_a_i,
  input  rv_isa_pkg::word_t        rf_rdata_b_i,
  input  rv_isa_pkg::word_t        fw_ex_data_i,
  input  rv_isa_pkg::word_t        fw_wb_data_i,
  input  logic                     ex_ready_i,
  output rv_isa_pkg::rf_addr_t     rf_raddr_a_o,
  output rv_isa_pkg::rf_addr_t     rf_raddr_b_o,
  output logic [1:0]               rf_re_o,
  output rv_isa_pkg::word_t        jmp_target_o,
  output logic                     id_ready_o,
  output logic                     id_valid_o,
  output id_pipe_pkg::id_ex_pipe_t id_ex_pipe_o
);

  import rv_isa_pkg::*;
  import id_pipe_pkg::*;

  dec_t  dec;
  word_t operand_a;
  word_t operand_b;
  word_t operand_c;

  // Source registers sit at fixed bits in every format
  assign rf_raddr_a_o = if_id_pipe_i.instr.r.rs1;
  assign rf_raddr_b_o = if_id_pipe_i.instr.r.rs2;
  assign rf_re_o      = dec.rf_re;

  id_decoder u_decoder (
    .instr_i (if_id_pipe_i.instr),
    .dec_o   (dec)
  );

  id_operand_sel u_operand_sel (
    .instr_i      (if_id_pipe_i.instr),
    .pc_i         (if_id_pipe_i.pc),
    .dec_i        (dec),
    .ctrl_i       (ctrl_i),
    .rf_rdata_a_i (rf_rdata_a_i),
    .rf_rdata_b_i (rf_rdata_b_i),
    .fw_ex_data_i (fw_ex_data_i),
    .fw_wb_data_i (fw_wb_data_i),
    .operand_a_o  (operand_a),
    .operand_b_o  (operand_b),
    .operand_c_o  (operand_c),
    .jmp_target_o (jmp_target_o)
  );

  id_ex_pipe_reg u_pipe_reg (
    .clk          (clk),
    .rst_n        (rst_n),
    .if_id_pipe_i (if_id_pipe_i),
    .ctrl_i       (ctrl_i),
    .dec_i        (dec),
    .operand_a_i  (operand_a),
    .operand_b_i  (operand_b),
    .operand_c_i  (operand_c),
    .ex_ready_i   (ex_ready_i),
    .id_ready_o   (id_ready_o),
    .id_valid_o   (id_valid_o),
    .id_ex_pipe_o (id_ex_pipe_o)
  );

endmodule

// File: design/id_ex_pipe_reg.sv
// Stage ready/valid and the ID/EX register with per-unit field hold
module id_ex_pipe_reg (
  input  logic                     clk,
  input  logic                     rst_n,
  input  id_pipe_pkg::if_id_pipe_t if_id_pipe_i,
  input  id_pipe_pkg::ctrl_t       ctrl_i,
  input  id_pipe_pkg::dec_t        dec_i,
  input  rv_isa_pkg::word_t        operand_a_i,
  input  rv_isa_pkg::word_t        operand_b_i,
  input  rv_isa_pkg::word_t        operand_c_i,
  input  logic                     ex_ready_i,
  output logic                     id_ready_o,
  output logic                     id_valid_o,
  output id_pipe_pkg::id_ex_pipe_t id_ex_pipe_o
);

  import id_pipe_pkg::*;

  logic transfer;

  //////////////////////////////////////////////////////////////////////
  // Stage handshake
  //////////////////////////////////////////////////////////////////////

  // Kill and halt both suppress valid
  assign id_valid_o = if_id_pipe_i.instr_valid && !ctrl_i.kill_id && !ctrl_i.halt_id;
  // Kill frees the stage regardless of EX
  assign id_ready_o = ctrl_i.kill_id || (ex_ready_i && !ctrl_i.halt_id);
  assign transfer   = id_valid_o && ex_ready_i;

  //////////////////////////////////////////////////////////////////////
  // ID/EX register
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_ex_pipe_o <= '0;
    end else if (transfer) begin
      id_ex_pipe_o.instr_valid  <= 1'b1;
      id_ex_pipe_o.pc           <= if_id_pipe_i.pc;
      id_ex_pipe_o.alu_operator <= dec_i.alu_operator;
      id_ex_pipe_o.illegal_insn <= dec_i.illegal_insn;

      // Operands only when the instruction uses them
      if (dec_i.op_a_sel != OP_A_NONE) begin
        id_ex_pipe_o.operand_a <= operand_a_i;
      end
      if (dec_i.op_b_sel != OP_B_NONE) begin
        id_ex_pipe_o.operand_b <= operand_b_i;
      end
      if (dec_i.op_c_sel != OP_C_NONE) begin
        id_ex_pipe_o.operand_c <= operand_c_i;
      end

      // ALU flags
      id_ex_pipe_o.alu_en <= dec_i.alu_en;
      if (dec_i.alu_en) begin
        id_ex_pipe_o.alu_bch <= dec_i.alu_bch;
        id_ex_pipe_o.alu_jmp <= dec_i.alu_jmp;
      end

      // LSU detail
      id_ex_pipe_o.lsu_en <= dec_i.lsu_en;
      if (dec_i.lsu_en) begin
        id_ex_pipe_o.lsu_we   <= dec_i.lsu_we;
        id_ex_pipe_o.lsu_size <= dec_i.lsu_size;
        id_ex_pipe_o.lsu_sext <= dec_i.lsu_sext;
      end

      // Writeback
      id_ex_pipe_o.rf_we <= dec_i.rf_we;
      if (dec_i.rf_we) begin
        id_ex_pipe_o.rf_waddr <= if_id_pipe_i.instr.r.rd;
      end
    end else if (ex_ready_i) begin
      // Bubble into EX
      id_ex_pipe_o.instr_valid <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  // A killed instruction never reaches EX
  a_kill_no_valid : assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_i.kill_id && ex_ready_i |=> !id_ex_pipe_o.instr_valid);

  // Back-pressure freezes the whole register
  a_hold_on_stall : assert property (@(posedge clk) disable iff (!rst_n)
    !ex_ready_i |=> $stable(id_ex_pipe_o));

endmodule

// File: design/id_operand_sel.sv
// Immediate generation, forwarding and operand muxes, plus the branch/jump target adder
module id_operand_sel (
  input  rv_isa_pkg::instr_u instr_i,
  input  rv_isa_pkg::word_t  pc_i,
  input  id_pipe_pkg::dec_t  dec_i,
  input  id_pipe_pkg::ctrl_t ctrl_i,
  input  rv_isa_pkg::word_t  rf_rdata_a_i,
  input  rv_isa_pkg::word_t  rf_rdata_b_i,
  input  rv_isa_pkg::word_t  fw_ex_data_i,
  input  rv_isa_pkg::word_t  fw_wb_data_i,
  output rv_isa_pkg::word_t  operand_a_o,
  output rv_isa_pkg::word_t  operand_b_o,
  output rv_isa_pkg::word_t  operand_c_o,
  output rv_isa_pkg::word_t  jmp_target_o
);

  import rv_isa_pkg::*;
  import id_pipe_pkg::*;

  word_t imm_i;
  word_t imm_s;
  word_t imm_sb;
  word_t imm_u;
  word_t imm_uj;
  word_t imm_b;
  word_t op_a_fw;
  word_t op_b_fw;
  word_t jalr_fw;
  word_t tgt_base;
  word_t tgt_offs;
  word_t tgt_sum;

  // One forwarding choice per source operand
  function automatic word_t fw_mux(fw_sel_e sel, word_t ex, word_t wb, word_t rf);
    case (sel)
      SEL_FW_EX: return ex;
      SEL_FW_WB: return wb;
      default:   return rf;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Sign extended immediates
  //////////////////////////////////////////////////////////////////////
  assign imm_i  = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
  assign imm_s  = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
  // B format shuffles the S immediate bits
  assign imm_sb = {{19{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi[6], instr_i.s.imm_lo[0],
                   instr_i.s.imm_hi[5:0], instr_i.s.imm_lo[4:1], 1'b0};
  assign imm_u  = {instr_i.u.imm, 12'b0};
  // J format shuffles the U immediate bits
  assign imm_uj = {{12{instr_i.u.imm[19]}}, instr_i.u.imm[7:0], instr_i.u.imm[8],
                   instr_i.u.imm[18:9], 1'b0};

  //////////////////////////////////////////////////////////////////////
  // Forwarding
  //////////////////////////////////////////////////////////////////////
  assign op_a_fw = fw_mux(ctrl_i.op_a_fw_sel, fw_ex_data_i, fw_wb_data_i, rf_rdata_a_i);
  assign op_b_fw = fw_mux(ctrl_i.op_b_fw_sel, fw_ex_data_i, fw_wb_data_i, rf_rdata_b_i);
  // Jump base never comes from EX, the controller stalls instead
  assign jalr_fw = (ctrl_i.jalr_fw_sel == SEL_FW_WB) ? fw_wb_data_i : rf_rdata_a_i;

  //////////////////////////////////////////////////////////////////////
  // Target adder, shared by JAL, JALR and branches
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    tgt_base = pc_i;
    case (dec_i.bch_jmp_sel)
      BCH_JMP_JALR: begin
        tgt_base = jalr_fw;
        tgt_offs = imm_i;
      end
      BCH_JMP_BCH: tgt_offs = imm_sb;
      default:     tgt_offs = imm_uj;
    endcase
  end

  assign tgt_sum = tgt_base + tgt_offs;
  // JALR clears the low target bit
  assign jmp_target_o = (dec_i.bch_jmp_sel == BCH_JMP_JALR) ? {tgt_sum[XLEN-1:1], 1'b0} : tgt_sum;

  //////////////////////////////////////////////////////////////////////
  // Operand muxes
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    case (dec_i.imm_b_sel)
      IMMB_S:      imm_b = imm_s;
      IMMB_U:      imm_b = imm_u;
      IMMB_PCINCR: imm_b = PC_INCR;
      default:     imm_b = imm_i;
    endcase
  end

  always_comb begin
    case (dec_i.op_a_sel)
      OP_A_CURRPC: operand_a_o = pc_i;
      OP_A_ZERO:   operand_a_o = '0;
      default:     operand_a_o = op_a_fw;
    endcase
  end

  assign operand_b_o = (dec_i.op_b_sel == OP_B_IMM) ? imm_b : op_b_fw;
  // Branch target rides along in operand C
  assign operand_c_o = (dec_i.op_c_sel == OP_C_BCH) ? tgt_sum : op_b_fw;

endmodule

// File: design/id_decoder.sv
// RV32I opcode decoder, turns the ID instruction into unit enables and mux selects
module id_decoder (
  input  rv_isa_pkg::instr_u instr_i,
  output id_pipe_pkg::dec_t  dec_o
);

  import rv_isa_pkg::*;
  import id_pipe_pkg::*;

  logic [2:0] funct3;
  logic       funct7_b5;
  logic       is_op;

  assign funct3    = instr_i.r.funct3;
  // Selects SUB and SRA
  assign funct7_b5 = instr_i.r.funct7[5];
  assign is_op     = instr_i.r.opcode == OPC_OP;

  always_comb begin
    dec_o = DEC_IDLE;

    case (instr_i.r.opcode)
      ////////////////////////////////////////////////////////////////////
      // Integer register and immediate arithmetic
      ////////////////////////////////////////////////////////////////////
      OPC_OP, OPC_OPIMM: begin
        dec_o.alu_en   = 1'b1;
        dec_o.rf_we    = 1'b1;
        dec_o.op_a_sel = OP_A_REGA_OR_FWD;
        if (is_op) begin
          dec_o.op_b_sel = OP_B_REGB_OR_FWD;
          dec_o.rf_re    = 2'b11;
        end else begin
          dec_o.op_b_sel = OP_B_IMM;
          dec_o.rf_re    = 2'b01;
        end
        case (funct3)
          // Immediate bit 10 is not a SUB flag for ADDI
          3'b000:  dec_o.alu_operator = (is_op && funct7_b5) ? ALU_SUB : ALU_ADD;
          3'b001:  dec_o.alu_operator = ALU_SLL;
          3'b010:  dec_o.alu_operator = ALU_SLT;
          3'b011:  dec_o.alu_operator = ALU_SLTU;
          3'b100:  dec_o.alu_operator = ALU_XOR;
          3'b101:  dec_o.alu_operator = funct7_b5 ? ALU_SRA : ALU_SRL;
          3'b110:  dec_o.alu_operator = ALU_OR;
          default: dec_o.alu_operator = ALU_AND;
        endcase
      end

      // Upper immediates, added to zero or to the PC
      OPC_LUI, OPC_AUIPC: begin
        dec_o.alu_en    = 1'b1;
        dec_o.rf_we     = 1'b1;
        dec_o.op_a_sel  = (instr_i.r.opcode == OPC_LUI) ? OP_A_ZERO : OP_A_CURRPC;
        dec_o.op_b_sel  = OP_B_IMM;
        dec_o.imm_b_sel = IMMB_U;
      end

      ////////////////////////////////////////////////////////////////////
      // Jumps and branches
      ////////////////////////////////////////////////////////////////////
      OPC_JAL, OPC_JALR: begin
        // Link value PC + 4 computed in the ALU
        dec_o.alu_en    = 1'b1;
        dec_o.alu_jmp   = 1'b1;
        dec_o.rf_we     = 1'b1;
        dec_o.op_a_sel  = OP_A_CURRPC;
        dec_o.op_b_sel  = OP_B_IMM;
        dec_o.imm_b_sel = IMMB_PCINCR;
        if (instr_i.r.opcode == OPC_JALR) begin
          dec_o.bch_jmp_sel = BCH_JMP_JALR;
          dec_o.rf_re       = 2'b01;
        end
      end

      OPC_BRANCH: begin
        dec_o.alu_en      = 1'b1;
        dec_o.alu_bch     = 1'b1;
        dec_o.op_a_sel    = OP_A_REGA_OR_FWD;
        dec_o.op_b_sel    = OP_B_REGB_OR_FWD;
        dec_o.op_c_sel    = OP_C_BCH;
        dec_o.bch_jmp_sel = BCH_JMP_BCH;
        dec_o.rf_re       = 2'b11;
        case (funct3)
          3'b000:  dec_o.alu_operator = ALU_EQ;
          3'b001:  dec_o.alu_operator = ALU_NE;
          3'b100:  dec_o.alu_operator = ALU_LT;
          3'b101:  dec_o.alu_operator = ALU_GE;
          3'b110:  dec_o.alu_operator = ALU_LTU;
          3'b111:  dec_o.alu_operator = ALU_GEU;
          default: dec_o.illegal_insn = 1'b1;
        endcase
      end

      ////////////////////////////////////////////////////////////////////
      // Loads and stores, address is rs1 plus immediate
      ////////////////////////////////////////////////////////////////////
      OPC_LOAD: begin
        dec_o.lsu_en    = 1'b1;
        dec_o.rf_we     = 1'b1;
        dec_o.op_a_sel  = OP_A_REGA_OR_FWD;
        dec_o.op_b_sel  = OP_B_IMM;
        dec_o.rf_re     = 2'b01;
        dec_o.lsu_size  = lsu_size_e'(funct3[1:0]);
        // LBU and LHU zero extend
        dec_o.lsu_sext  = !funct3[2];
        if (funct3[1:0] == 2'b11 || funct3 == 3'b110) begin
          dec_o.illegal_insn = 1'b1;
        end
      end

      OPC_STORE: begin
        dec_o.lsu_en    = 1'b1;
        dec_o.lsu_we    = 1'b1;
        dec_o.op_a_sel  = OP_A_REGA_OR_FWD;
        dec_o.op_b_sel  = OP_B_IMM;
        dec_o.imm_b_sel = IMMB_S;
        // Store data
        dec_o.op_c_sel  = OP_C_REGB_OR_FWD;
        dec_o.rf_re     = 2'b11;
        dec_o.lsu_size  = lsu_size_e'(funct3[1:0]);
        if (funct3[2] || funct3[1:0] == 2'b11) begin
          dec_o.illegal_insn = 1'b1;
        end
      end

      default: dec_o.illegal_insn = 1'b1;
    endcase

    // Illegal words use no unit; both ports read speculatively
    if (dec_o.illegal_insn) begin
      dec_o              = DEC_IDLE;
      dec_o.rf_re        = 2'b11;
      dec_o.illegal_insn = 1'b1;
    end

    // At most one execution unit per instruction
    a_alu_lsu_excl : assert (!(dec_o.alu_en && dec_o.lsu_en));
  end

endmodule

// File: design/id_pipe_pkg.sv
// Decode stage pipeline types: mux selects, ALU operators and stage structs
package id_pipe_pkg;

  import rv_isa_pkg::*;

  // ALU operators, branch compares included
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL,
    ALU_SRA, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_OR, ALU_AND, ALU_EQ, ALU_NE,
    ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_opcode_e;

  ////////////////////////////////////////////////////////////////////
  // Mux selects
  ////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    OP_A_REGA_OR_FWD, OP_A_CURRPC, OP_A_ZERO, OP_A_NONE
  } op_a_sel_e;

  typedef enum logic [1:0] {
    OP_B_REGB_OR_FWD, OP_B_IMM, OP_B_NONE
  } op_b_sel_e;

  // Operand C carries store data or branch target
  typedef enum logic [1:0] {
    OP_C_REGB_OR_FWD, OP_C_BCH, OP_C_NONE
  } op_c_sel_e;

  typedef enum logic [2:0] {
    IMMB_I, IMMB_S, IMMB_U, IMMB_PCINCR
  } imm_b_sel_e;

  // Target adder input
  typedef enum logic [1:0] {
    BCH_JMP_JAL, BCH_JMP_JALR, BCH_JMP_BCH
  } bch_jmp_sel_e;

  typedef enum logic [1:0] {
    SEL_FW_EX, SEL_FW_WB, SEL_REGFILE
  } fw_sel_e;

  typedef enum logic [1:0] {
    LSU_BYTE, LSU_HALF, LSU_WORD
  } lsu_size_e;

  ////////////////////////////////////////////////////////////////////
  // Stage structs
  ////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic   instr_valid;
    word_t  pc;
    instr_u instr;
  } if_id_pipe_t;

  // Controller levels and forwarding selects
  typedef struct packed {
    logic    kill_id;
    logic    halt_id;
    fw_sel_e op_a_fw_sel;
    fw_sel_e op_b_fw_sel;
    fw_sel_e jalr_fw_sel;
  } ctrl_t;

  // Decoder outputs
  typedef struct packed {
    logic         alu_en;
    logic         alu_bch;
    logic         alu_jmp;
    alu_opcode_e  alu_operator;
    op_a_sel_e    op_a_sel;
    op_b_sel_e    op_b_sel;
    op_c_sel_e    op_c_sel;
    imm_b_sel_e   imm_b_sel;
    bch_jmp_sel_e bch_jmp_sel;
    logic         lsu_en;
    logic         lsu_we;
    lsu_size_e    lsu_size;
    logic         lsu_sext;
    logic [1:0]   rf_re;
    logic         rf_we;
    logic         illegal_insn;
  } dec_t;

  // Decoder output with no unit enabled and no operand used
  localparam dec_t DEC_IDLE = '{
    alu_operator: ALU_ADD,
    op_a_sel:     OP_A_NONE,
    op_b_sel:     OP_B_NONE,
    op_c_sel:     OP_C_NONE,
    imm_b_sel:    IMMB_I,
    bch_jmp_sel:  BCH_JMP_JAL,
    lsu_size:     LSU_BYTE,
    rf_re:        2'b00,
    default:      1'b0
  };

  typedef struct packed {
    logic        instr_valid;
    word_t       pc;
    logic        alu_en;
    logic        alu_bch;
    logic        alu_jmp;
    alu_opcode_e alu_operator;
    word_t       operand_a;
    word_t       operand_b;
    word_t       operand_c;
    logic        lsu_en;
    logic        lsu_we;
    lsu_size_e   lsu_size;
    logic        lsu_sext;
    logic        rf_we;
    rf_addr_t    rf_waddr;
    logic        illegal_insn;
  } id_ex_pipe_t;

endpackage

// File: design/rv_isa_pkg.sv
// RV32I encoding definitions, imported by every decode stage RTL file
package rv_isa_pkg;

  // Data and address width
  localparam int unsigned XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      rf_addr_t;

  // Major opcodes handled by the stage, anything else is illegal
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'h03,
    OPC_OPIMM  = 7'h13,
    OPC_AUIPC  = 7'h17,
    OPC_STORE  = 7'h23,
    OPC_OP     = 7'h33,
    OPC_LUI    = 7'h37,
    OPC_BRANCH = 7'h63,
    OPC_JALR   = 7'h67,
    OPC_JAL    = 7'h6f
  } opcode_e;

  ////////////////////////////////////////////////////////////////////
  // Encoding formats, all 32 bits wide
  ////////////////////////////////////////////////////////////////////

  // Register-register, also gives funct7 for shift immediates
  typedef struct packed {
    logic [6:0] funct7;
    rf_addr_t   rs2;
    rf_addr_t   rs1;
    logic [2:0] funct3;
    rf_addr_t   rd;
    logic [6:0] opcode;
  } instr_r_t;

  // Immediate, loads and JALR
  typedef struct packed {
    logic [11:0] imm;
    rf_addr_t    rs1;
    logic [2:0]  funct3;
    rf_addr_t    rd;
    logic [6:0]  opcode;
  } instr_i_t;

  // Stores; branches reuse this split immediate
  typedef struct packed {
    logic [6:0] imm_hi;
    rf_addr_t   rs2;
    rf_addr_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } instr_s_t;

  // Upper immediate; JAL reuses the 20-bit field
  typedef struct packed {
    logic [19:0] imm;
    rf_addr_t    rd;
    logic [6:0]  opcode;
  } instr_u_t;

  // One instruction word seen through each format
  typedef union packed {
    instr_r_t r;
    instr_i_t i;
    instr_s_t s;
    instr_u_t u;
  } instr_u;

  // Return address step, no compressed instructions
  localparam word_t PC_INCR = 32'd4;

endpackage
